// ==== verilog/split_pkg.sv ====
// Split midend shared types
package split_pkg;

  // Byte address and byte count widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned LenWidth  = 32;

  // A byte address in the system map
  typedef logic [AddrWidth-1:0] addr_t;

  // A transfer length in bytes
  typedef logic [LenWidth-1:0] len_t;

  // One burst as handed from the frontend to the backend
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_bytes;
  } burst_req_t;

  // Status returned by the backend towards the frontend
  // trans_complete pulses once per finished transfer
  typedef struct packed {
    logic backend_idle;
    logic trans_complete;
  } meta_t;

  // Splitter FSM states
  // SplitIdle passes fitting requests straight through,
  // SplitBusy issues the stored request piece by piece
  typedef enum logic {
    SplitIdle,
    SplitBusy
  } split_state_e;

endpackage

// ==== verilog/burst_splitter.sv ====
// Region boundary burst splitter
`timescale 1ns/10ps

module burst_splitter #(
  parameter int unsigned      RegionBytes = 64,
  parameter split_pkg::addr_t SpmStart    = 32'h0000_0000,
  parameter split_pkg::addr_t SpmEnd      = 32'h1000_0000
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Request side
  input  split_pkg::burst_req_t burst_req_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  // Backend side
  output split_pkg::burst_req_t burst_req_o,
  output logic                  valid_o,
  input  logic                  ready_i,
  // One pulse per piece accepted by the backend
  output logic                  piece_fire_o
);

  import split_pkg::*;

  split_state_e state_q, state_d;

  // Remaining part of a request being split
  burst_req_t req_q, req_d;

  // High when the source side decides alignment of the stored request
  logic src_side_q, src_side_d;

  logic  src_in_spm;
  addr_t align_addr;
  addr_t region_offset;
  len_t  region_room;
  logic  req_fits;
  logic  last_piece;
  len_t  piece_len;

  // Source inside the SPM window aligns on the source, else on the destination
  assign src_in_spm = (burst_req_i.src >= SpmStart) && (burst_req_i.src < SpmEnd);

  // While busy the side picked at accept time keeps deciding alignment
  always_comb begin
    if (state_q == SplitBusy) begin
      align_addr = src_side_q ? req_q.src : req_q.dst;
    end else begin
      align_addr = src_in_spm ? burst_req_i.src : burst_req_i.dst;
    end
  end

  // Bytes left up to the next region boundary
  assign region_offset = align_addr & addr_t'(RegionBytes - 1);
  assign region_room   = len_t'(RegionBytes) - len_t'(region_offset);

  // Incoming request fits within one region
  assign req_fits = burst_req_i.num_bytes <= region_room;

  // Stored request ends within the current region
  assign last_piece = req_q.num_bytes <= region_room;
  assign piece_len  = last_piece ? req_q.num_bytes : region_room;

  always_comb begin
    state_d      = state_q;
    req_d        = req_q;
    src_side_d   = src_side_q;
    burst_req_o  = burst_req_i;
    valid_o      = 1'b0;
    ready_o      = 1'b0;
    piece_fire_o = 1'b0;

    unique case (state_q)
      SplitIdle: begin
        if (req_fits) begin
          // Zero latency pass-through, back-pressure goes straight back
          valid_o      = valid_i;
          ready_o      = ready_i;
          piece_fire_o = valid_i & ready_i;
        end else begin
          // Take the request, pieces start on the next cycle
          ready_o = 1'b1;
          if (valid_i) begin
            req_d      = burst_req_i;
            src_side_d = src_in_spm;
            state_d    = SplitBusy;
          end
        end
      end

      SplitBusy: begin
        burst_req_o           = req_q;
        burst_req_o.num_bytes = piece_len;
        valid_o               = 1'b1;
        piece_fire_o          = ready_i;
        if (ready_i) begin
          // Both sides move together by the length just issued
          req_d.src       = req_q.src + addr_t'(piece_len);
          req_d.dst       = req_q.dst + addr_t'(piece_len);
          req_d.num_bytes = req_q.num_bytes - piece_len;
          if (last_piece) begin
            state_d = SplitIdle;
          end
        end
      end

      default: begin
        state_d = SplitIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= SplitIdle;
      src_side_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      src_side_q <= src_side_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q <= req_d;
  end

  // Region arithmetic relies on a power of two size
  initial begin
    assert (RegionBytes > 1 && (RegionBytes & (RegionBytes - 1)) == 0)
      else $fatal(1, "RegionBytes must be a power of two");
  end

  // A stalled piece must not change until the backend takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(burst_req_o))
    else $error("burst_req_o changed while stalled");

  // Every piece handed to the backend moves at least one byte
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    piece_fire_o |-> burst_req_o.num_bytes != '0)
    else $error("zero length piece issued");

endmodule

// ==== verilog/trans_tracker.sv ====
// In-flight transfer tracker
`timescale 1ns/10ps

module trans_tracker #(
  parameter int unsigned CountWidth = 8
) (
  input  logic clk_i,
  input  logic rst_ni,
  // A piece was accepted by the backend
  input  logic piece_fire_i,
  // The backend finished one piece
  input  logic trans_complete_i,
  // Last outstanding piece just finished
  output logic trans_complete_o
);

  logic [CountWidth-1:0] count_q, count_d;

  // Issue and completion may land in the same cycle and cancel out
  always_comb begin
    count_d = count_q;
    if (piece_fire_i) begin
      count_d = count_d + CountWidth'(1);
    end
    if (trans_complete_i) begin
      count_d = count_d - CountWidth'(1);
    end
  end

  // Pulse only on the step from one outstanding piece to none
  assign trans_complete_o = (count_q == CountWidth'(1)) && (count_d == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  // Backend never reports more completions than pieces issued
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    trans_complete_i && !piece_fire_i |-> count_q != '0)
    else $error("completion without outstanding piece");

  // Counter must be wide enough for the backend queue depth
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    piece_fire_i && !trans_complete_i |-> count_q != '1)
    else $error("in-flight counter overflow");

endmodule

// ==== verilog/split_midend.sv ====
// DMA split midend top level
`timescale 1ns/10ps

module split_midend #(
  parameter int unsigned      RegionBytes = 64,
  parameter split_pkg::addr_t SpmStart    = 32'h0000_0000,
  parameter split_pkg::addr_t SpmEnd      = 32'h1000_0000,
  parameter int unsigned      CountWidth  = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Frontend
  input  split_pkg::burst_req_t burst_req_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output split_pkg::meta_t      meta_o,
  // Backend
  output split_pkg::burst_req_t burst_req_o,
  output logic                  valid_o,
  input  logic                  ready_i,
  input  split_pkg::meta_t      meta_i
);

  logic piece_fire;
  logic tracker_complete;

  burst_splitter #(
    .RegionBytes (RegionBytes),
    .SpmStart    (SpmStart),
    .SpmEnd      (SpmEnd)
  ) u_splitter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .burst_req_i  (burst_req_i),
    .valid_i      (valid_i),
    .ready_o      (ready_o),
    .burst_req_o  (burst_req_o),
    .valid_o      (valid_o),
    .ready_i      (ready_i),
    .piece_fire_o (piece_fire)
  );

  // Counts pieces at the backend so the frontend sees one completion per request
  trans_tracker #(
    .CountWidth (CountWidth)
  ) u_tracker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .piece_fire_i     (piece_fire),
    .trans_complete_i (meta_i.trans_complete),
    .trans_complete_o (tracker_complete)
  );

  // Idle level goes back untouched
  assign meta_o.backend_idle   = meta_i.backend_idle;
  assign meta_o.trans_complete = tracker_complete;

endmodule

// ==== dv/tb_split_checker.sv ====
// Split midend reference checker
`timescale 1ns/10ps

module tb_split_checker #(
  parameter int unsigned      RegionBytes = 64,
  parameter split_pkg::addr_t SpmStart    = 32'h0000_0000,
  parameter split_pkg::addr_t SpmEnd      = 32'h1000_0000
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Frontend handshake
  input  split_pkg::burst_req_t in_req_i,
  input  logic                  in_valid_i,
  input  logic                  in_ready_i,
  // Backend handshake
  input  split_pkg::burst_req_t out_req_i,
  input  logic                  out_valid_i,
  input  logic                  out_ready_i,
  // Metadata on both sides
  input  split_pkg::meta_t      meta_in_i,
  input  split_pkg::meta_t      meta_out_i,
  output logic                  error_o,
  output logic [15:0]           pending_o
);

  import split_pkg::*;

  typedef burst_req_t piece_list_t[$];

  // What each expected piece belongs to
  typedef struct packed {
    logic src_side;
    logic last;
    len_t total;
  } piece_info_t;

  piece_list_t   expected_q;
  piece_info_t   info_q[$];
  burst_req_t    held_req;
  logic          held_valid;
  int            in_flight;
  len_t          bytes_seen;
  logic          failed;
  logic [15:0]   pending;

  assign error_o   = failed;
  assign pending_o = pending;

  function automatic logic src_aligns(input addr_t src);
    return (src >= SpmStart) && (src < SpmEnd);
  endfunction

  // Pieces the request must be cut into, never crossing a region on the aligning side
  function automatic piece_list_t split_reference(input burst_req_t req);
    piece_list_t pieces;
    burst_req_t  piece;
    logic        src_side;
    len_t        remaining;
    len_t        room;
    addr_t       align;
    src_side  = src_aligns(req.src);
    piece     = req;
    remaining = req.num_bytes;
    while (remaining != 0) begin
      align           = src_side ? piece.src : piece.dst;
      room            = len_t'(RegionBytes) - len_t'(align % RegionBytes);
      piece.num_bytes = (remaining < room) ? remaining : room;
      pieces.push_back(piece);
      piece.src = piece.src + piece.num_bytes;
      piece.dst = piece.dst + piece.num_bytes;
      remaining = remaining - piece.num_bytes;
    end
    return pieces;
  endfunction

  task automatic check_value(input string test_name, input logic [95:0] expected,
                             input logic [95:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %0h, actual %0h", test_name, expected, actual);
      failed = 1'b1;
    end
  endtask

  initial begin : compare_responses
    piece_list_t pieces;
    burst_req_t  exp_piece;
    piece_info_t info;
    addr_t       align;
    logic        busy;
    logic        fire;
    logic        expected_pulse;
    int          next_flight;
    failed     = 1'b0;
    held_valid = 1'b0;
    held_req   = '0;
    in_flight  = 0;
    bytes_seen = '0;
    pending    = '0;
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        busy = expected_q.size() != 0;
        if (held_valid) begin
          check_value("stalled valid_o", 96'(1'b1), 96'(out_valid_i));
          check_value("stalled piece", held_req, out_req_i);
        end
        if (busy) begin
          check_value("ready_o while splitting", 96'(1'b0), 96'(in_ready_i));
        end else if (!in_valid_i) begin
          check_value("idle valid_o", 96'(1'b0), 96'(out_valid_i));
        end
        if (in_valid_i) begin
          pieces = split_reference(in_req_i);
          if (!busy && pieces.size() == 1) begin
            check_value("pass-through piece", in_req_i, out_req_i);
            check_value("pass-through valid_o", 96'(1'b1), 96'(out_valid_i));
            check_value("pass-through ready_o", 96'(out_ready_i), 96'(in_ready_i));
          end else if (!busy) begin
            // A request that needs splitting is taken at once, with no piece yet
            check_value("accept valid_o", 96'(1'b0), 96'(out_valid_i));
            check_value("accept ready_o", 96'(1'b1), 96'(in_ready_i));
          end
          if (in_ready_i) begin
            foreach (pieces[i]) begin
              info.src_side = src_aligns(in_req_i.src);
              info.last     = (i == pieces.size() - 1);
              info.total    = in_req_i.num_bytes;
              expected_q.push_back(pieces[i]);
              info_q.push_back(info);
            end
          end
        end
        fire = out_valid_i && out_ready_i;
        if (fire) begin
          if (expected_q.size() == 0) begin
            $display("A piece reached the backend without a matching request");
            failed = 1'b1;
          end else begin
            exp_piece = expected_q.pop_front();
            info      = info_q.pop_front();
            check_value("split piece", exp_piece, out_req_i);
            align = info.src_side ? out_req_i.src : out_req_i.dst;
            check_value("region boundary", 96'(1'b1),
                        96'((align % RegionBytes) + out_req_i.num_bytes <= RegionBytes));
            bytes_seen = bytes_seen + out_req_i.num_bytes;
            if (info.last) begin
              check_value("length sum", 96'(info.total), 96'(bytes_seen));
              bytes_seen = '0;
            end
          end
        end
        // Completion is due when the last outstanding piece returns
        next_flight    = in_flight + int'(fire) - int'(meta_in_i.trans_complete);
        expected_pulse = (in_flight != 0) && (next_flight == 0);
        check_value("completion pulse", 96'(expected_pulse), 96'(meta_out_i.trans_complete));
        check_value("backend idle", 96'(meta_in_i.backend_idle),
                    96'(meta_out_i.backend_idle));
        in_flight  = next_flight;
        held_valid = out_valid_i && !out_ready_i;
        held_req   = out_req_i;
        pending    = 16'(expected_q.size());
      end
    end
  end

endmodule

// ==== dv/tb_split_midend.sv ====
// Split midend testbench
`timescale 1ns/10ps

module tb_split_midend;

  import split_pkg::*;

  localparam int unsigned RegionBytes = 64;
  localparam addr_t       SpmStart    = 32'h0000_0000;
  localparam addr_t       SpmEnd      = 32'h1000_0000;
  localparam int unsigned NumReqs     = 60;
  localparam int unsigned ClkPeriod   = 8;
  localparam int unsigned ResetCycles = 10;

  logic        clk;
  logic        rst_n;
  burst_req_t  req_in;
  burst_req_t  req_out;
  logic        valid_in;
  logic        ready_out;
  logic        valid_out;
  logic        ready_in;
  meta_t       meta_in;
  meta_t       meta_out;
  logic        check_failed;
  logic [15:0] pieces_pending;

  logic [31:0] lfsr = 32'h99532c8b;
  burst_req_t  requests[NumReqs];
  int unsigned due_q[$];
  int unsigned watchdog_cycles;
  logic        stimulus_ready = 1'b0;

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int unsigned width);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < width; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  split_midend #(
    .RegionBytes (RegionBytes),
    .SpmStart    (SpmStart),
    .SpmEnd      (SpmEnd),
    .CountWidth  (8)
  ) UUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .burst_req_i (req_in),
    .valid_i     (valid_in),
    .ready_o     (ready_out),
    .meta_o      (meta_out),
    .burst_req_o (req_out),
    .valid_o     (valid_out),
    .ready_i     (ready_in),
    .meta_i      (meta_in)
  );

  tb_split_checker #(
    .RegionBytes (RegionBytes),
    .SpmStart    (SpmStart),
    .SpmEnd      (SpmEnd)
  ) u_checker (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .in_req_i    (req_in),
    .in_valid_i  (valid_in),
    .in_ready_i  (ready_out),
    .out_req_i   (req_out),
    .out_valid_i (valid_out),
    .out_ready_i (ready_in),
    .meta_in_i   (meta_in),
    .meta_out_i  (meta_out),
    .error_o     (check_failed),
    .pending_o   (pieces_pending)
  );

  // Mixed source-in-SPM and destination-in-SPM requests, some short enough to pass
  task automatic build_requests(output int unsigned regions);
    addr_t spm_addr;
    addr_t far_addr;
    len_t  len;
    regions     = 0;
    requests[0] = '{src: 32'h0000_0108, dst: 32'h8000_0010, num_bytes: 32'd16};
    requests[1] = '{src: 32'h8000_0004, dst: 32'h0000_0030, num_bytes: 32'd200};
    for (int unsigned n = 2; n < NumReqs; n++) begin
      spm_addr = random_bits(28);
      far_addr = 32'h8000_0000 | random_bits(28);
      if (random_bits(2) == 32'd0) begin
        len = 32'd1 + (random_bits(6) % 32'd64);
      end else begin
        len = 32'd1 + (random_bits(9) % 32'd300);
      end
      if (random_bits(1) != 32'd0) begin
        requests[n] = '{src: spm_addr, dst: far_addr, num_bytes: len};
      end else begin
        requests[n] = '{src: far_addr, dst: spm_addr, num_bytes: len};
      end
    end
    for (int unsigned n = 0; n < NumReqs; n++) begin
      regions = regions + requests[n].num_bytes / RegionBytes + 2;
    end
  endtask

  // Starts and ends on a falling edge
  task automatic send_request(input burst_req_t req);
    logic accepted;
    req_in   = req;
    valid_in = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = ready_out;
      @(negedge clk);
    end
    valid_in = 1'b0;
    req_in   = '0;
  endtask

  // Random stalls, and one completion per piece after a random delay
  initial begin : backend_model
    int unsigned cycle;
    int unsigned due;
    int unsigned last_due;
    cycle    = 0;
    last_due = 0;
    ready_in = 1'b0;
    meta_in  = '{backend_idle: 1'b1, trans_complete: 1'b0};
    forever begin
      @(posedge clk);
      cycle = cycle + 1;
      // A piece joins the queue on the edge that accepts it
      if (rst_n && valid_out && ready_in) begin
        due = cycle + 1 + random_bits(3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
      end
      @(negedge clk);
      ready_in               = random_bits(2) != 32'd0;
      meta_in.trans_complete = 1'b0;
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        void'(due_q.pop_front());
        meta_in.trans_complete = 1'b1;
      end
      meta_in.backend_idle = due_q.size() == 0;
    end
  end

  initial begin : watchdog
    wait (stimulus_ready);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  always @(posedge check_failed) begin
    $display("Some tests failed");
    $fatal(1, "check failed");
  end

  initial begin : stimulus
    int unsigned regions;
    int unsigned gap;
    rst_n    = 1'b0;
    valid_in = 1'b0;
    req_in   = '0;
    build_requests(regions);
    watchdog_cycles = 20 * regions + 1000;
    stimulus_ready  = 1'b1;
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
    // Quiet period after reset
    repeat (5) @(negedge clk);
    for (int unsigned n = 0; n < NumReqs; n++) begin
      send_request(requests[n]);
      gap = random_bits(2);
      repeat (gap) @(negedge clk);
    end
    while (pieces_pending != 0 || due_q.size() != 0 || !meta_in.backend_idle) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
    if (check_failed) begin
      $display("Some tests failed");
      $fatal(1, "check failed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// ==== all.f ====
verilog/split_pkg.sv
verilog/burst_splitter.sv
verilog/trans_tracker.sv
verilog/split_midend.sv
dv/tb_split_checker.sv
dv/tb_split_midend.sv

// ==== Makefile ====
# Verilator simulation of the split midend
#
#   make compile   build the simulation binary
#   make run       build if needed and run, exit status reports pass or fail
#   make clean     remove build output

VERILATOR ?= verilator
TOP       ?= tb_split_midend
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
SIMFLAGS  ?=

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(SIMFLAGS)

clean:
	rm -rf $(BUILD_DIR)
